// ==== common/exu_alu_pkg.sv ====
`default_nettype none

`include "exu_alu_settings.svh"

package exu_alu_pkg;

  ////////////////////
  // Decode info views
  ////////////////////

  // Operation flags of a regular ALU instruction
  typedef struct packed {
    logic op_add;
    logic op_sub;
    logic op_xor;
    logic op_sll;
    logic op_srl;
    logic op_sra;
    logic op_or;
    logic op_and;
    logic op_slt;
    logic op_sltu;
    logic op_lui;
  } alu_ops_t;

  // Compare flags of a conditional branch
  typedef struct packed {
    logic beq;
    logic bne;
    logic blt;
    logic bge;
    logic bltu;
    logic bgeu;
  } bjp_cmp_t;

  // Group sits first in both views so it decodes from either one
  typedef struct packed {
    logic [`DECINFO_GRP_WIDTH-1:0]                    grp;
    alu_ops_t                                         ops;
    logic                                             op2imm;
    logic                                             op1pc;
    logic [`DECINFO_WIDTH-`DECINFO_GRP_WIDTH-14:0]    rsv;
  } alu_info_t;

  typedef struct packed {
    logic [`DECINFO_GRP_WIDTH-1:0]                    grp;
    logic                                             jump;
    logic                                             bprdt;
    bjp_cmp_t                                         cmp;
    logic [`DECINFO_WIDTH-`DECINFO_GRP_WIDTH-9:0]     rsv;
  } bjp_info_t;

  // One decode word, read per group
  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
  } decinfo_u;

  ////////////////////
  // Issue and results
  ////////////////////

  typedef struct packed {
    logic [`XLEN-1:0]        rs1;
    logic [`XLEN-1:0]        rs2;
    logic [`XLEN-1:0]        imm;
    logic [`PC_SIZE-1:0]     pc;
    logic                    pc_vld;
    logic [`RFIDX_WIDTH-1:0] rdidx;
    logic                    rdwen;
    logic                    ilegl;
    decinfo_u                info;
  } issue_t;

  // Requests into the shared datapath, all zero when idle
  typedef struct packed {
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    alu_ops_t         ops;
  } alu_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] add_op1;
    logic [`XLEN-1:0] add_op2;
    bjp_cmp_t         cmp;
  } bjp_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] alu_res;
    logic             cmp_res;
    logic [`XLEN-1:0] add_res;
  } dpath_rsp_t;

  typedef struct packed {
    logic [`PC_SIZE-1:0] pc;
    logic                pc_vld;
    logic [`XLEN-1:0]    imm;
    logic                bjp;
    logic                bjp_prdt;
    logic                bjp_rslv;
    logic                ilegl;
  } cmt_t;

  typedef struct packed {
    logic [`XLEN-1:0]        wdat;
    logic [`RFIDX_WIDTH-1:0] rdidx;
  } wbck_t;

endpackage

`default_nettype wire

// ==== common/exu_alu_settings.svh ====
`ifndef EXU_ALU_SETTINGS_SVH
`define EXU_ALU_SETTINGS_SVH

// Data path and address widths
`define XLEN              32
`define PC_SIZE           32

// Register file index width
`define RFIDX_WIDTH       5

// Decode info word, shared by every instruction group
`define DECINFO_WIDTH     16
`define DECINFO_GRP_WIDTH 2

// Instruction group codes held in the top bits of the decode word
`define DECINFO_GRP_ALU    2'd0
`define DECINFO_GRP_BJP    2'd1

// Reserved for load/store and multiply/divide, not served by this unit
`define DECINFO_GRP_AGU    2'd2
`define DECINFO_GRP_MULDIV 2'd3

// Link offset for jumps and branches
`define BJP_LINK_OFS      4

`endif

// ==== exu_alu.f ====
+incdir+common
common/exu_alu_pkg.sv
hw/exu_alu/exu_alu_ctrl.sv
hw/exu_alu/exu_alu_rglr.sv
hw/exu_alu/exu_alu_bjp.sv
hw/exu_alu/exu_alu_dpath.sv
hw/exu_alu.sv
testbench/tb_exu_alu.sv

// ==== hw/exu_alu.sv ====
`default_nettype none

`include "exu_alu_settings.svh"

module exu_alu (
  input  wire                       clk,
  input  wire                       i_rst_n,

  // Issue from dispatch
  input  wire                       i_valid,
  output logic                      o_ready,
  input  wire exu_alu_pkg::issue_t  i_issue,

  // Commit channel
  output logic                      o_cmt_valid,
  input  wire                       i_cmt_ready,
  output exu_alu_pkg::cmt_t         o_cmt,

  // Write-back channel
  output logic                      o_wbck_valid,
  input  wire                       i_wbck_ready,
  output exu_alu_pkg::wbck_t        o_wbck
);

  ////////////////////
  // Internal wiring
  ////////////////////

  logic                    alu_sel;
  logic                    bjp_sel;
  logic [`XLEN-1:0]        alu_wdat;
  logic [`XLEN-1:0]        bjp_wdat;
  exu_alu_pkg::cmt_t       bjp_flags;
  exu_alu_pkg::alu_req_t   alu_req;
  exu_alu_pkg::bjp_req_t   bjp_req;
  exu_alu_pkg::dpath_rsp_t dpath_rsp;

  // Group decode and output handshake
  exu_alu_ctrl u_exu_alu_ctrl (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_issue      (i_issue),
    .o_alu_sel    (alu_sel),
    .o_bjp_sel    (bjp_sel),
    .i_alu_wdat   (alu_wdat),
    .i_bjp_wdat   (bjp_wdat),
    .i_bjp_flags  (bjp_flags),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck       (o_wbck)
  );

  // Regular ALU requester
  exu_alu_rglr u_exu_alu_rglr (
    .i_sel   (alu_sel),
    .i_issue (i_issue),
    .o_req   (alu_req),
    .i_rsp   (dpath_rsp),
    .o_wdat  (alu_wdat)
  );

  // Branch and jump requester
  exu_alu_bjp u_exu_alu_bjp (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_sel   (bjp_sel),
    .i_issue (i_issue),
    .o_req   (bjp_req),
    .o_wdat  (bjp_wdat),
    .o_flags (bjp_flags),
    .i_rsp   (dpath_rsp)
  );

  // Shared datapath
  exu_alu_dpath u_exu_alu_dpath (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_alu_req (alu_req),
    .i_bjp_req (bjp_req),
    .o_rsp     (dpath_rsp)
  );

endmodule

`default_nettype wire

// ==== hw/exu_alu/exu_alu_bjp.sv ====
`default_nettype none

`include "exu_alu_settings.svh"

module exu_alu_bjp (
  input  wire                          clk,
  input  wire                          i_rst_n,

  input  wire                          i_sel,
  input  wire exu_alu_pkg::issue_t     i_issue,

  output exu_alu_pkg::bjp_req_t        o_req,
  // Link value
  output logic [`XLEN-1:0]             o_wdat,
  // Only bjp, bjp_prdt and bjp_rslv carry meaning
  output exu_alu_pkg::cmt_t            o_flags,
  input  wire exu_alu_pkg::dpath_rsp_t i_rsp
);

  exu_alu_pkg::bjp_info_t info;

  // Branch view of the decode word
  assign info = i_issue.info.bjp;

  // Compare rs1 with rs2, link adder forms pc + 4
  always_comb begin
    o_req = '0;
    if (i_sel) begin
      o_req.op1     = i_issue.rs1;
      o_req.op2     = i_issue.rs2;
      o_req.add_op1 = `XLEN'(i_issue.pc);
      o_req.add_op2 = `XLEN'(`BJP_LINK_OFS);
      o_req.cmp     = info.cmp;
    end
  end

  assign o_wdat = i_rsp.add_res;

  ////////////////////
  // Resolution
  ////////////////////

  // Jumps are always taken
  always_comb begin
    o_flags          = '0;
    o_flags.bjp      = i_sel;
    o_flags.bjp_prdt = i_sel & info.bprdt;
    o_flags.bjp_rslv = i_sel & (info.jump | i_rsp.cmp_res);
  end

  // A jump carries no compare
  a_jump_no_cmp: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_sel |-> !(info.jump && (|info.cmp))
  );

endmodule

`default_nettype wire

// ==== hw/exu_alu/exu_alu_ctrl.sv ====
`default_nettype none

`include "exu_alu_settings.svh"

module exu_alu_ctrl (
  input  wire                       clk,
  input  wire                       i_rst_n,

  input  wire                       i_valid,
  output logic                      o_ready,
  input  wire exu_alu_pkg::issue_t  i_issue,

  // Unit selects
  output logic                      o_alu_sel,
  output logic                      o_bjp_sel,

  // Unit results
  input  wire [`XLEN-1:0]           i_alu_wdat,
  input  wire [`XLEN-1:0]           i_bjp_wdat,
  input  wire exu_alu_pkg::cmt_t    i_bjp_flags,

  output logic                      o_cmt_valid,
  input  wire                       i_cmt_ready,
  output exu_alu_pkg::cmt_t         o_cmt,

  output logic                      o_wbck_valid,
  input  wire                       i_wbck_ready,
  output exu_alu_pkg::wbck_t        o_wbck
);

  ////////////////////
  // Group decode
  ////////////////////

  logic [`DECINFO_GRP_WIDTH-1:0] grp;
  logic                          excp;
  logic                          rsv_grp;
  logic                          need_wbck;

  // Group field sits in the same place in either view
  assign grp  = i_issue.info.alu.grp;
  // Fetch exception overrides any group
  assign excp = i_issue.ilegl;

  assign o_alu_sel = ~excp & (grp == `DECINFO_GRP_ALU);
  assign o_bjp_sel = ~excp & (grp == `DECINFO_GRP_BJP);

  // Load/store and mul/div codes have no unit here
  assign rsv_grp = (grp == `DECINFO_GRP_AGU) | (grp == `DECINFO_GRP_MULDIV);

  ////////////////////
  // Result select
  ////////////////////

  // Exception and idle both fall through to zero
  assign o_wbck.wdat  = ({`XLEN{o_alu_sel}} & i_alu_wdat)
                      | ({`XLEN{o_bjp_sel}} & i_bjp_wdat);
  assign o_wbck.rdidx = i_issue.rdidx;

  // Commit record
  assign o_cmt.pc       = i_issue.pc;
  assign o_cmt.pc_vld   = i_issue.pc_vld;
  assign o_cmt.imm      = i_issue.imm;
  assign o_cmt.ilegl    = i_issue.ilegl;
  // Branch flags only from the branch unit
  assign o_cmt.bjp      = o_bjp_sel & i_bjp_flags.bjp;
  assign o_cmt.bjp_prdt = o_bjp_sel & i_bjp_flags.bjp_prdt;
  assign o_cmt.bjp_rslv = o_bjp_sel & i_bjp_flags.bjp_rslv;

  ////////////////////
  // Handshake split
  ////////////////////

  // Every instruction commits and only rd writers write back
  assign need_wbck = i_issue.rdwen;

  // Each valid waits on the other channel's ready so both fire together
  assign o_ready      = i_cmt_ready & (need_wbck ? i_wbck_ready : 1'b1);
  assign o_wbck_valid = i_valid & need_wbck & i_cmt_ready;
  assign o_cmt_valid  = i_valid & (need_wbck ? i_wbck_ready : 1'b1);

  // Decode must never hand over a reserved group
  a_no_rsv_grp: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (i_valid && !excp) |-> !rsv_grp
  );

endmodule

`default_nettype wire

// ==== hw/exu_alu/exu_alu_dpath.sv ====
`default_nettype none

`include "exu_alu_settings.svh"

module exu_alu_dpath (
  input  wire                        clk,
  input  wire                        i_rst_n,

  // Idle requesters drive all zero
  input  wire exu_alu_pkg::alu_req_t i_alu_req,
  input  wire exu_alu_pkg::bjp_req_t i_bjp_req,

  output exu_alu_pkg::dpath_rsp_t    o_rsp
);

  // Reverse bit order, lets one right shifter also shift left
  function automatic logic [`XLEN-1:0] bit_rev(input logic [`XLEN-1:0] d);
    logic [`XLEN-1:0] r;
    for (int i = 0; i < `XLEN; i++) begin
      r[i] = d[`XLEN-1-i];
    end
    return r;
  endfunction

  exu_alu_pkg::alu_ops_t ops;
  exu_alu_pkg::bjp_cmp_t cmp;
  logic [`XLEN-1:0]      op1;
  logic [`XLEN-1:0]      op2;
  logic                  alu_act;
  logic                  bjp_act;

  // Merge requesters
  assign op1 = i_alu_req.op1 | i_bjp_req.op1;
  assign op2 = i_alu_req.op2 | i_bjp_req.op2;
  assign ops = i_alu_req.ops;
  assign cmp = i_bjp_req.cmp;

  ////////////////////
  // Adder/subtractor
  ////////////////////

  logic             sub_op;
  logic             sgn_op;
  logic [`XLEN:0]   add_a;
  logic [`XLEN:0]   add_b;
  logic [`XLEN:0]   add_sum;
  logic             lt_flag;

  assign sub_op = ops.op_sub | ops.op_slt | ops.op_sltu
                | cmp.blt | cmp.bge | cmp.bltu | cmp.bgeu;
  assign sgn_op = ops.op_slt | cmp.blt | cmp.bge;

  // One extra bit, sign or zero extended, holds the less-than flag
  assign add_a   = {sgn_op & op1[`XLEN-1], op1};
  assign add_b   = {sgn_op & op2[`XLEN-1], op2} ^ {(`XLEN+1){sub_op}};
  assign add_sum = add_a + add_b + {{`XLEN{1'b0}}, sub_op};
  assign lt_flag = add_sum[`XLEN];

  ////////////////////
  // Shifter and logic
  ////////////////////

  logic [4:0]       shamt;
  logic [`XLEN-1:0] shin;
  logic [`XLEN-1:0] shr;
  logic [`XLEN-1:0] sra_fill;
  logic [`XLEN-1:0] xor_res;

  // Only the low five bits of op2 count
  assign shamt    = op2[4:0];
  assign shin     = ops.op_sll ? bit_rev(op1) : op1;
  assign shr      = shin >> shamt;
  // Vacated upper bits take the sign for sra
  assign sra_fill = ~({`XLEN{1'b1}} >> shamt) & {`XLEN{op1[`XLEN-1]}};
  assign xor_res  = op1 ^ op2;

  // ALU result is an AND-OR of the active operation
  assign o_rsp.alu_res =
      ({`XLEN{ops.op_add | ops.op_sub}} & add_sum[`XLEN-1:0])
    | ({`XLEN{ops.op_xor}}  & xor_res)
    | ({`XLEN{ops.op_or}}   & (op1 | op2))
    | ({`XLEN{ops.op_and}}  & (op1 & op2))
    | ({`XLEN{ops.op_sll}}  & bit_rev(shr))
    | ({`XLEN{ops.op_srl}}  & shr)
    | ({`XLEN{ops.op_sra}}  & (shr | sra_fill))
    | ({`XLEN{ops.op_slt | ops.op_sltu}} & {{(`XLEN-1){1'b0}}, lt_flag})
    | ({`XLEN{ops.op_lui}}  & op2);

  // Equality from the xor, ordering from the subtract
  assign o_rsp.cmp_res = (cmp.beq  & ~(|xor_res))
                       | (cmp.bne  &  (|xor_res))
                       | ((cmp.blt | cmp.bltu) &  lt_flag)
                       | ((cmp.bge | cmp.bgeu) & ~lt_flag);

  // Link adder
  assign o_rsp.add_res = i_bjp_req.add_op1 + i_bjp_req.add_op2;

  // Branch request is live on a compare or a nonzero link offset
  assign alu_act = |i_alu_req.ops;
  assign bjp_act = (|i_bjp_req.cmp) | (|i_bjp_req.add_op2);

  // Group selects upstream keep the requesters apart
  a_one_req: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    !(alu_act && bjp_act)
  );

endmodule

`default_nettype wire

// ==== hw/exu_alu/exu_alu_rglr.sv ====
`default_nettype none

`include "exu_alu_settings.svh"

module exu_alu_rglr (
  // Selected by group decode
  input  wire                          i_sel,
  input  wire exu_alu_pkg::issue_t     i_issue,

  // Datapath request and answer
  output exu_alu_pkg::alu_req_t        o_req,
  input  wire exu_alu_pkg::dpath_rsp_t i_rsp,

  // Write-back data
  output logic [`XLEN-1:0]             o_wdat
);

  exu_alu_pkg::alu_info_t info;
  logic [`XLEN-1:0]       op1;
  logic [`XLEN-1:0]       op2;

  // ALU view of the decode word
  assign info = i_issue.info.alu;

  ////////////////////
  // Operand select
  ////////////////////

  // auipc style ops take the PC as first operand
  assign op1 = info.op1pc ? `XLEN'(i_issue.pc) : i_issue.rs1;

  // I-type and lui take the immediate
  assign op2 = info.op2imm ? i_issue.imm : i_issue.rs2;

  // Idle request stays all zero so the datapath can OR requesters
  always_comb begin
    o_req = '0;
    if (i_sel) begin
      o_req.op1 = op1;
      o_req.op2 = op2;
      o_req.ops = info.ops;
    end
  end

  // Datapath result goes straight to write-back
  assign o_wdat = i_rsp.alu_res;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the exu_alu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f exu_alu.f --top-module tb_exu_alu -Mdir obj_dir

./obj_dir/Vtb_exu_alu | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== testbench/tb_exu_alu.sv ====
`default_nettype none

`include "exu_alu_settings.svh"

module tb_exu_alu;

  ////////////////////
  // Model encodings
  ////////////////////

  // ALU operation codes of the reference model
  localparam logic [3:0] code_add  = 4'd0;
  localparam logic [3:0] code_sub  = 4'd1;
  localparam logic [3:0] code_xor  = 4'd2;
  localparam logic [3:0] code_or   = 4'd3;
  localparam logic [3:0] code_and  = 4'd4;
  localparam logic [3:0] code_sll  = 4'd5;
  localparam logic [3:0] code_srl  = 4'd6;
  localparam logic [3:0] code_sra  = 4'd7;
  localparam logic [3:0] code_slt  = 4'd8;
  localparam logic [3:0] code_sltu = 4'd9;
  localparam logic [3:0] code_lui  = 4'd10;

  // Branch kinds with an unconditional jump last
  localparam logic [2:0] kind_beq  = 3'd0;
  localparam logic [2:0] kind_bne  = 3'd1;
  localparam logic [2:0] kind_blt  = 3'd2;
  localparam logic [2:0] kind_bge  = 3'd3;
  localparam logic [2:0] kind_bltu = 3'd4;
  localparam logic [2:0] kind_bgeu = 3'd5;
  localparam logic [2:0] kind_jump = 3'd6;

  // Cycles a handshake may take before it counts as stuck
  localparam int wait_limit = 20;

  logic                    clk;
  logic                    rst_n;
  logic                    valid;
  logic                    ready;
  logic                    cmt_valid;
  logic                    cmt_ready;
  logic                    wbck_valid;
  logic                    wbck_ready;
  exu_alu_pkg::issue_t     issue;
  exu_alu_pkg::cmt_t       cmt;
  exu_alu_pkg::wbck_t      wbck;

  int n_tests;
  int n_checks;
  int n_errors;
  int test_start_errors;

  exu_alu uut (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_valid      (valid),
    .o_ready      (ready),
    .i_issue      (issue),
    .o_cmt_valid  (cmt_valid),
    .i_cmt_ready  (cmt_ready),
    .o_cmt        (cmt),
    .o_wbck_valid (wbck_valid),
    .i_wbck_ready (wbck_ready),
    .o_wbck       (wbck)
  );

  // Clock with period 8
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic exu_alu_pkg::alu_ops_t ops_from_code(input logic [3:0] code);
    exu_alu_pkg::alu_ops_t o;
    o = '0;
    case (code)
      code_add:  o.op_add  = 1'b1;
      code_sub:  o.op_sub  = 1'b1;
      code_xor:  o.op_xor  = 1'b1;
      code_or:   o.op_or   = 1'b1;
      code_and:  o.op_and  = 1'b1;
      code_sll:  o.op_sll  = 1'b1;
      code_srl:  o.op_srl  = 1'b1;
      code_sra:  o.op_sra  = 1'b1;
      code_slt:  o.op_slt  = 1'b1;
      code_sltu: o.op_sltu = 1'b1;
      code_lui:  o.op_lui  = 1'b1;
      default:   o = '0;
    endcase
    return o;
  endfunction

  // Result of one ALU operation on the chosen operands
  function automatic logic [`XLEN-1:0] alu_model(input logic [3:0] code,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] r;
    r = '0;
    case (code)
      code_add:  r = a + b;
      code_sub:  r = a - b;
      code_xor:  r = a ^ b;
      code_or:   r = a | b;
      code_and:  r = a & b;
      // Shift amount is the low five bits only
      code_sll:  r = a << b[4:0];
      code_srl:  r = a >> b[4:0];
      code_sra:  r = $signed(a) >>> b[4:0];
      code_slt:  r[0] = $signed(a) < $signed(b);
      code_sltu: r[0] = a < b;
      default:   r = b;
    endcase
    return r;
  endfunction

  // Taken or not for each branch kind
  function automatic logic branch_model(input logic [2:0] kind, input logic [`XLEN-1:0] a,
                                        input logic [`XLEN-1:0] b);
    case (kind)
      kind_beq:  return a == b;
      kind_bne:  return a != b;
      kind_blt:  return $signed(a) < $signed(b);
      kind_bge:  return $signed(a) >= $signed(b);
      kind_bltu: return a < b;
      kind_bgeu: return a >= b;
      default:   return 1'b1;
    endcase
  endfunction

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    assert (got === exp) else begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %s finished with %0d errors", name, n_errors - test_start_errors);
    test_start_errors = n_errors;
  endtask

  // Waits for the commit transfer up to wait_limit cycles
  task automatic wait_commit(output bit done);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!(cmt_valid && cmt_ready) && cycles < wait_limit) begin
      cycles++;
      @(posedge clk);
    end
    done = cmt_valid && cmt_ready;
    if (!done) begin
      $display("commit handshake did not complete within %0d cycles at %0t", wait_limit, $time);
      n_errors++;
    end
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Random operands and word aligned pc with rd written
  function automatic exu_alu_pkg::issue_t random_issue();
    exu_alu_pkg::issue_t iss;
    iss        = '0;
    iss.rs1    = $urandom;
    iss.rs2    = $urandom;
    iss.imm    = $urandom;
    iss.pc     = $urandom & ~32'd3;
    iss.pc_vld = 1'($urandom);
    iss.rdidx  = `RFIDX_WIDTH'($urandom);
    iss.rdwen  = 1'b1;
    return iss;
  endfunction

  // Drives one instruction and checks both channels at its commit
  task automatic issue_and_check(input exu_alu_pkg::issue_t iss,
                                 input logic [`XLEN-1:0] exp_wdat,
                                 input logic exp_bjp, input logic exp_rslv,
                                 input logic exp_prdt);
    bit done;
    @(negedge clk);
    issue = iss;
    valid = 1'b1;
    wait_commit(done);
    if (done) begin
      check_value("o_wbck.wdat", wbck.wdat, exp_wdat);
      check_value("o_wbck.rdidx", `XLEN'(wbck.rdidx), `XLEN'(iss.rdidx));
      check_value("o_cmt.pc", cmt.pc, iss.pc);
      check_value("o_cmt.imm", cmt.imm, iss.imm);
      check_bit("o_cmt.pc_vld", cmt.pc_vld, iss.pc_vld);
      check_bit("o_cmt.ilegl", cmt.ilegl, iss.ilegl);
      check_bit("o_cmt.bjp", cmt.bjp, exp_bjp);
      check_bit("o_cmt.bjp_rslv", cmt.bjp_rslv, exp_rslv);
      check_bit("o_cmt.bjp_prdt", cmt.bjp_prdt, exp_prdt);
      check_bit("o_wbck_valid", wbck_valid, iss.rdwen);
    end
    @(negedge clk);
    valid = 1'b0;
  endtask

  task automatic alu_case(input logic [3:0] code, input logic [`XLEN-1:0] a,
                          input logic [`XLEN-1:0] b, input logic op2imm, input logic op1pc);
    exu_alu_pkg::issue_t iss;
    logic [`XLEN-1:0]    op1;
    logic [`XLEN-1:0]    op2;
    iss                 = random_issue();
    iss.rs1             = a;
    iss.rs2             = b;
    iss.info.alu.grp    = `DECINFO_GRP_ALU;
    iss.info.alu.ops    = ops_from_code(code);
    iss.info.alu.op2imm = op2imm;
    iss.info.alu.op1pc  = op1pc;
    // Operand choice as decode flags ask
    op1 = op1pc ? iss.pc : a;
    op2 = op2imm ? iss.imm : b;
    issue_and_check(iss, alu_model(code, op1, op2), 1'b0, 1'b0, 1'b0);
  endtask

  task automatic bjp_case(input logic [2:0] kind, input logic [`XLEN-1:0] a,
                          input logic [`XLEN-1:0] b);
    exu_alu_pkg::issue_t iss;
    iss                   = random_issue();
    iss.rs1               = a;
    iss.rs2               = b;
    iss.info.bjp.grp      = `DECINFO_GRP_BJP;
    iss.info.bjp.jump     = (kind == kind_jump);
    iss.info.bjp.bprdt    = 1'($urandom);
    iss.info.bjp.cmp.beq  = (kind == kind_beq);
    iss.info.bjp.cmp.bne  = (kind == kind_bne);
    iss.info.bjp.cmp.blt  = (kind == kind_blt);
    iss.info.bjp.cmp.bge  = (kind == kind_bge);
    iss.info.bjp.cmp.bltu = (kind == kind_bltu);
    iss.info.bjp.cmp.bgeu = (kind == kind_bgeu);
    // Link value is pc + 4
    issue_and_check(iss, iss.pc + 32'd4, 1'b1, branch_model(kind, a, b),
                    iss.info.bjp.bprdt);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic idle_after_reset();
    @(posedge clk);
    check_bit("o_cmt_valid", cmt_valid, 1'b0);
    check_bit("o_wbck_valid", wbck_valid, 1'b0);
    finish_test("idle_after_reset");
  endtask

  task automatic arith_logic_ops();
    logic [3:0] codes [6];
    codes = '{code_add, code_sub, code_xor, code_or, code_and, code_lui};
    // Every op with each mix of imm and pc operands
    foreach (codes[c]) begin
      for (int sel = 0; sel < 4; sel++) begin
        alu_case(codes[c], $urandom, $urandom, sel[0], sel[1]);
      end
    end
    finish_test("arith_logic_ops");
  endtask

  task automatic shifts_and_set_less();
    logic [`XLEN-1:0] edges [4];
    edges = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000};
    // Random op2 has upper bits set that the shift must ignore
    for (int n = 0; n < 6; n++) begin
      alu_case(code_sll, $urandom, $urandom, 1'b0, 1'b0);
      alu_case(code_srl, $urandom, $urandom, 1'b0, 1'b0);
      alu_case(code_sra, $urandom | 32'h8000_0000, $urandom, 1'b0, 1'b0);
      alu_case(code_sra, $urandom & 32'h7fff_ffff, $urandom, 1'b0, 1'b0);
    end
    alu_case(code_sll, $urandom, $urandom, 1'b1, 1'b0);
    // Boundary pairs where signed and unsigned order disagree
    foreach (edges[i]) begin
      foreach (edges[j]) begin
        alu_case(code_slt, edges[i], edges[j], 1'b0, 1'b0);
        alu_case(code_sltu, edges[i], edges[j], 1'b0, 1'b0);
      end
    end
    finish_test("shifts_and_set_less");
  endtask

  task automatic branch_compares();
    logic [`XLEN-1:0] a;
    for (int k = 0; k < 7; k++) begin
      for (int n = 0; n < 4; n++) begin
        a = $urandom;
        bjp_case(3'(k), a, $urandom);
        bjp_case(3'(k), a, a);
      end
      bjp_case(3'(k), 32'h8000_0000, 32'h7fff_ffff);
    end
    finish_test("branch_compares");
  endtask

  task automatic illegal_instr();
    exu_alu_pkg::issue_t iss;
    // Every group code including reserved ones with a random decode word
    for (int g = 0; g < 4; g++) begin
      for (int n = 0; n < 3; n++) begin
        iss              = random_issue();
        iss.info         = 16'($urandom);
        iss.info.alu.grp = 2'(g);
        iss.ilegl        = 1'b1;
        iss.rdwen        = 1'($urandom);
        issue_and_check(iss, '0, 1'b0, 1'b0, 1'b0);
      end
    end
    finish_test("illegal_instr");
  endtask

  task automatic handshake_no_rd();
    exu_alu_pkg::issue_t iss;
    iss              = random_issue();
    iss.info.alu.grp = `DECINFO_GRP_ALU;
    iss.info.alu.ops = ops_from_code(code_add);
    iss.rdwen        = 1'b0;
    @(negedge clk);
    issue      = iss;
    valid      = 1'b1;
    cmt_ready  = 1'b0;
    wbck_ready = 1'b1;
    @(posedge clk);
    // Commit valid does not wait on its own ready
    check_bit("o_cmt_valid", cmt_valid, 1'b1);
    check_bit("o_ready", ready, 1'b0);
    check_bit("o_wbck_valid", wbck_valid, 1'b0);
    // Write-back ready must not matter without rd
    @(negedge clk);
    cmt_ready  = 1'b1;
    wbck_ready = 1'b0;
    @(posedge clk);
    check_bit("o_cmt_valid", cmt_valid, 1'b1);
    check_bit("o_ready", ready, 1'b1);
    check_bit("o_wbck_valid", wbck_valid, 1'b0);
    @(negedge clk);
    valid      = 1'b0;
    wbck_ready = 1'b1;
    finish_test("handshake_no_rd");
  endtask

  task automatic handshake_with_rd();
    exu_alu_pkg::issue_t iss;
    iss              = random_issue();
    iss.info.alu.grp = `DECINFO_GRP_ALU;
    iss.info.alu.ops = ops_from_code(code_xor);
    @(negedge clk);
    issue      = iss;
    cmt_ready  = 1'b1;
    wbck_ready = 1'b1;
    @(posedge clk);
    check_bit("o_cmt_valid", cmt_valid, 1'b0);
    check_bit("o_wbck_valid", wbck_valid, 1'b0);
    check_bit("o_ready", ready, 1'b1);
    // Both valids in the cycle that i_valid rises
    @(negedge clk);
    valid = 1'b1;
    @(posedge clk);
    check_bit("o_cmt_valid", cmt_valid, 1'b1);
    check_bit("o_wbck_valid", wbck_valid, 1'b1);
    check_bit("o_ready", ready, 1'b1);
    check_value("o_wbck.wdat", wbck.wdat, iss.rs1 ^ iss.rs2);
    // Write-back stall holds back the commit too
    @(negedge clk);
    wbck_ready = 1'b0;
    @(posedge clk);
    check_bit("o_cmt_valid", cmt_valid, 1'b0);
    check_bit("o_ready", ready, 1'b0);
    check_bit("o_wbck_valid", wbck_valid, 1'b1);
    @(negedge clk);
    valid      = 1'b0;
    wbck_ready = 1'b1;
    finish_test("handshake_with_rd");
  endtask

  initial begin
    void'($urandom(13121));
    n_tests           = 0;
    n_checks          = 0;
    n_errors          = 0;
    test_start_errors = 0;
    rst_n             = 1'b0;
    valid             = 1'b0;
    issue             = '0;
    cmt_ready         = 1'b1;
    wbck_ready        = 1'b1;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    idle_after_reset();
    arith_logic_ops();
    shifts_and_set_less();
    branch_compares();
    illegal_instr();
    handshake_no_rd();
    handshake_with_rd();

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
